// File: vlog.f
logic/vp_pkg.sv
logic/video_crop.sv
logic/pixel_fifo.sv
logic/nn_scaler.sv
logic/line_pad.sv
logic/video_proc_top.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/tb_video_proc.sv

// File: Bender.yml
package:
  name: video_proc

sources:
  # design, in compile order
  - files:
      - logic/vp_pkg.sv
      - logic/video_crop.sv
      - logic/pixel_fifo.sv
      - logic/nn_scaler.sv
      - logic/line_pad.sv
      - logic/video_proc_top.sv

  # testbench, top module tb_video_proc
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_checker.sv
      - testbench/tb_video_proc.sv

// File: testbench/tb_video_proc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_video_proc;

    localparam int h_disp    = 32;
    localparam int v_disp    = 8;
    localparam int out_x     = 12;
    localparam int out_y     = 4;
    localparam int n_cfg     = 2;               // 0 downscale, 1 unity crop
    localparam int blank     = 40;              // idle cycles after a line
    localparam int min_blank = h_disp - out_x;  // fill time of line_pad
    localparam int limit     = 3 * 6 * v_disp * (h_disp + 40) + 200;

    wire         clk_vp;
    wire         rst_n;
    logic        rst_req;
    logic        vi_vs;
    logic        vi_de;
    logic [15:0] vi_data;
    wire         vp_vs [n_cfg];
    wire         vp_de [n_cfg];
    wire  [15:0] vp_data [n_cfg];
    wire         vp_ovf [n_cfg];
    wire  [31:0] chk_err [n_cfg];
    wire  [31:0] chk_done [n_cfg];
    int          seed;
    int          cycles;
    int          err_mark;
    int          frames_sent;
    int          passed;
    int          failed;

    tb_clock clock_gen (
        .clk_vp    (clk_vp),
        .rst_req_i (rst_req),
        .rst_n_o   (rst_n)
    );

    // both configs see the same input; only window and scale differ
    for (genvar g = 0; g < n_cfg; g++) begin : g_cfg
        localparam int end_x = (g == 0) ? 28 : 16;  // 24 wide or 12 wide
        localparam int end_y = (g == 0) ? 8 : 4;

        video_proc_top #(
            .h_disp (h_disp), .v_disp (v_disp),
            .start_x (4), .start_y (0), .end_x (end_x), .end_y (end_y),
            .out_x (out_x), .out_y (out_y), .fifo_depth (64)
        ) dut (
            .clk_vp (clk_vp), .rst_n_i (rst_n),
            .vi_vs_i (vi_vs), .vi_de_i (vi_de), .vi_data_i (vi_data),
            .vp_vs_o (vp_vs[g]), .vp_de_o (vp_de[g]), .vp_data_o (vp_data[g]),
            .vp_overflow_o (vp_ovf[g])
        );

        tb_checker #(
            .h_disp (h_disp), .v_disp (v_disp),
            .start_x (4), .start_y (0), .end_x (end_x), .end_y (end_y),
            .out_x (out_x), .out_y (out_y), .cfg_id (g)
        ) chk (
            .clk_vp (clk_vp), .rst_n_i (rst_n),
            .vi_vs_i (vi_vs), .vi_de_i (vi_de), .vi_data_i (vi_data),
            .vp_vs_i (vp_vs[g]), .vp_de_i (vp_de[g]), .vp_data_i (vp_data[g]),
            .vp_overflow_i (vp_ovf[g]), .err_cnt_o (chk_err[g]), .done_o (chk_done[g])
        );
    end

    // input pixel of pattern p at column x, line y
    function automatic logic [15:0] pixel_value(input int p, input int x, input int y);
        logic [15:0] v;
        case (p)
            0:       v = {5'(y), 6'(x), 5'(x ^ y)};  // gradient, position in the bits
            1:       v = 16'($random(seed));
            2:       v = 16'(x * 2053 + y * 1021 + 1);
            default: v = 16'hffff;                   // white, black fill stands out
        endcase
        return v;
    endfunction

    function automatic int error_total();
        int g;
        int sum;
        sum = 0;
        for (g = 0; g < n_cfg; g++) begin
            sum += chk_err[g];
        end
        return sum;
    endfunction

    function automatic bit frames_received();
        int g;
        for (g = 0; g < n_cfg; g++) begin
            if (chk_done[g] < frames_sent) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // vs pulse, idle cycle, then the lines with their blanking
    task automatic drive_frame(input int p, input int blk, input int lines);
        int x;
        int y;
        @(negedge clk_vp);
        vi_vs <= 1'b1;
        @(negedge clk_vp);
        vi_vs <= 1'b0;
        for (y = 0; y < lines; y++) begin
            for (x = 0; x < h_disp; x++) begin
                @(negedge clk_vp);
                vi_de   <= 1'b1;
                vi_data <= pixel_value(p, x, y);
            end
            @(negedge clk_vp);
            vi_de   <= 1'b0;
            vi_data <= 16'h0000;
            repeat (blk - 1) @(negedge clk_vp);
        end
    endtask

    task automatic run_frames(input int p, input int blk, input int n);
        int f;
        for (f = 0; f < n; f++) begin
            drive_frame(p, blk, v_disp);
        end
        frames_sent += n;
        while (!frames_received()) begin
            @(negedge clk_vp);  // timeout process ends a hang
        end
        repeat (40) @(negedge clk_vp);  // stray beats still show up
    endtask

    task automatic report_test(input int id, input string name);
        int errs;
        errs = error_total() - err_mark;
        if (errs == 0) begin
            passed++;
        end else begin
            failed++;
        end
        $display("test %0d %s: %s, %0d errors", id, name, (errs == 0) ? "pass" : "FAIL", errs);
        err_mark = error_total();
    endtask

    initial begin
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk_vp);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("Something failed");
        $finish;
    end

    initial begin
        seed        = 50;
        rst_req     = 1'b0;
        vi_vs       = 1'b0;
        vi_de       = 1'b0;
        vi_data     = 16'h0000;
        err_mark    = 0;
        frames_sent = 0;
        passed      = 0;
        failed      = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk_vp);
        end
        repeat (4) @(negedge clk_vp);
        run_frames(0, blank, 1);
        report_test(1, "gradient window");
        run_frames(2, blank, 1);
        report_test(2, "unity crop");
        run_frames(1, blank, 3);
        report_test(3, "random frames");
        run_frames(3, blank, 1);
        report_test(4, "black line fill");
        run_frames(0, min_blank, 3);
        report_test(5, "minimum blanking");
        // reset lands in line 2 while both DUTs still send pixels
        fork
            drive_frame(0, blank, v_disp);
            begin
                repeat (2 * (h_disp + blank) + 20) @(negedge clk_vp);
                rst_req <= 1'b1;
                @(negedge clk_vp);
                rst_req <= 1'b0;
            end
        join
        while (rst_n !== 1'b1) begin
            @(negedge clk_vp);
        end
        repeat (10) @(negedge clk_vp);
        run_frames(0, blank, 1);
        report_test(6, "reset mid-frame");
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 passed + failed, passed, failed, error_total());
        if (failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
    parameter int h_disp  = 32,
    parameter int v_disp  = 8,
    parameter int start_x = 4,
    parameter int start_y = 0,
    parameter int end_x   = 28,  // exclusive
    parameter int end_y   = 8,   // exclusive
    parameter int out_x   = 12,
    parameter int out_y   = 4,
    parameter int cfg_id  = 0
) (
    input  wire logic        clk_vp,
    input  wire logic        rst_n_i,
    input  wire logic        vi_vs_i,
    input  wire logic        vi_de_i,
    input  wire logic [15:0] vi_data_i,
    input  wire logic        vp_vs_i,
    input  wire logic        vp_de_i,
    input  wire logic [15:0] vp_data_i,
    input  wire logic        vp_overflow_i,
    output int               err_cnt_o,
    output int               done_o      // output frames fully received
);
    localparam int slots       = 4;                  // input frames kept for lookup
    localparam int frame_px    = h_disp * v_disp;
    localparam int frame_beats = out_y * h_disp;     // padded lines
    localparam int x_step      = ((end_x - start_x) * 16384) / out_x;  // Q4.14
    localparam int y_step      = ((end_y - start_y) * 16384) / out_y;

    logic [15:0] img [slots * frame_px];
    logic        vs_q;
    logic        de_q;
    logic        rst_q;       // high when the previous cycle was out of reset
    logic        cap_on;      // a vs edge seen since reset
    logic        frame_open;
    logic        ovf_seen;
    logic [15:0] exp_data;
    int          cap_slot;
    int          cx;
    int          cy;
    int          in_cnt;      // input frames started
    int          out_cnt;     // output frames started
    int          out_slot;
    int          beat;        // beats of the open output frame

    // reference model: expected beat b of the output frame held in slot s
    function automatic logic [15:0] expect_beat(input int s, input int b);
        int          j;
        int          k;
        int          src;
        logic [23:0] wide;
        j = b % h_disp;
        k = b / h_disp;
        if (j >= out_x) begin
            return 16'h0000;  // black fill up to h_disp
        end
        // nearest neighbour from the window origin
        src = s * frame_px + (start_y + (k * y_step) / 16384) * h_disp
            + start_x + (j * x_step) / 16384;
        wide = {img[src][15:11], 3'b000, img[src][10:5], 2'b00, img[src][4:0], 3'b000};
        return {wide[23:19], wide[15:10], wide[7:3]};  // rgb888 back to rgb565
    endfunction

    initial begin
        err_cnt_o = 0;
        done_o    = 0;
        rst_q     = 1'b1;  // first reset cycle sees pre-reset values
    end

    always @(posedge clk_vp) begin
        if (rst_n_i !== 1'b1) begin
            if (!rst_q && (vp_de_i !== 1'b0 || vp_vs_i !== 1'b0
                           || vp_data_i !== 16'h0000 || vp_overflow_i !== 1'b0)) begin
                $display("MISMATCH %0t: dut %0d outputs not low during reset", $time, cfg_id);
                err_cnt_o++;
            end
            rst_q      = 1'b0;
            vs_q       = 1'b0;
            de_q       = 1'b0;
            cap_on     = 1'b0;  // partial frame after reset is ignored
            frame_open = 1'b0;
            ovf_seen   = 1'b0;
            in_cnt     = 0;
            out_cnt    = 0;
        end else begin
            rst_q = 1'b1;
            // mirror each input frame into a slot
            if (vi_vs_i && !vs_q) begin
                cap_slot = in_cnt % slots;
                in_cnt++;
                cap_on = 1'b1;
                cx     = 0;
                cy     = 0;
            end else if (vi_de_i && cap_on) begin
                if (cx < h_disp && cy < v_disp) begin
                    img[cap_slot * frame_px + cy * h_disp + cx] = vi_data_i;
                end
                cx++;
            end else if (!vi_de_i && de_q) begin
                cx = 0;  // line ended
                cy++;
            end
            vs_q = vi_vs_i;
            de_q = vi_de_i;
            if (vp_overflow_i === 1'b1 && !ovf_seen) begin
                $display("%0t: dut %0d FIFO overflow, input pixels were dropped",
                         $time, cfg_id);
                ovf_seen = 1'b1;
                err_cnt_o++;
            end
            if (vp_vs_i === 1'b1) begin
                if (frame_open) begin
                    $display("%0t: dut %0d frame %0d cut short, %0d of %0d pixels arrived",
                             $time, cfg_id, out_cnt - 1, beat, frame_beats);
                    err_cnt_o++;
                end
                if (out_cnt >= in_cnt) begin
                    $display("%0t: dut %0d started an output frame with no input frame",
                             $time, cfg_id);
                    err_cnt_o++;
                end
                frame_open = 1'b1;
                out_slot   = out_cnt % slots;
                out_cnt++;
                beat = 0;
            end
            if (vp_de_i === 1'b1) begin
                if (!frame_open) begin
                    $display("%0t: dut %0d sent a pixel outside any frame", $time, cfg_id);
                    err_cnt_o++;
                end else begin
                    exp_data = expect_beat(out_slot, beat);
                    if (vp_data_i !== exp_data) begin
                        $display("MISMATCH %0t: dut %0d frame %0d line %0d col %0d got %h expected %h",
                                 $time, cfg_id, out_cnt - 1, beat / h_disp, beat % h_disp,
                                 vp_data_i, exp_data);
                        err_cnt_o++;
                    end
                    beat++;
                    if (beat == frame_beats) begin
                        frame_open = 1'b0;  // later beats count as extra
                        done_o++;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int rst_cycles = 8
) (
    output logic      clk_vp,
    input  wire logic rst_req_i,  // restarts the reset window
    output logic      rst_n_o
);
    int rst_cnt;

    initial begin
        clk_vp  = 1'b0;
        rst_n_o = 1'b0;   // low from time zero
        rst_cnt = 0;
        forever #5 clk_vp = ~clk_vp;  // 10 ns period
    end

    // reset moves on the falling edge, like the stimulus
    always @(negedge clk_vp) begin
        if (rst_req_i === 1'b1) begin
            rst_cnt <= 0;
            rst_n_o <= 1'b0;
        end else if (rst_cnt < rst_cycles - 1) begin
            rst_cnt <= rst_cnt + 1;
        end else begin
            rst_n_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/video_proc_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_proc_top #(
    parameter int unsigned h_disp     = 1280,
    parameter int unsigned v_disp     = 720,
    parameter int unsigned start_x    = 320,
    parameter int unsigned start_y    = 180,
    parameter int unsigned end_x      = 960,
    parameter int unsigned end_y      = 540,
    parameter int unsigned out_x      = 320,  // out_x <= crop width
    parameter int unsigned out_y      = 180,  // out_y <= crop height
    parameter int unsigned fifo_depth = 64
) (
    input  wire logic        clk_vp,
    input  wire logic        rst_n_i,
    input  wire logic        vi_vs_i,
    input  wire logic        vi_de_i,
    input  wire logic [15:0] vi_data_i,
    output logic             vp_vs_o,
    output logic             vp_de_o,
    output logic [15:0]      vp_data_o,
    output logic             vp_overflow_o
);
    import vp_pkg::*;

    // Q4.14 steps, crop size over output size
    localparam logic [scale_w-1:0] x_scale =
        scale_w'(((end_x - start_x) << scale_frac) / out_x);
    localparam logic [scale_w-1:0] y_scale =
        scale_w'(((end_y - start_y) << scale_frac) / out_y);

    logic        crop_we;
    fifo_entry_t crop_entry;
    fifo_entry_t fifo_rdata;
    logic        fifo_empty;
    logic        scaler_re;
    logic        scl_valid;
    rgb888_t     scl_pixel;
    logic        scl_sof;
    logic        pad_ready;

    video_crop #(
        .h_disp  (h_disp),
        .v_disp  (v_disp),
        .start_x (start_x),
        .start_y (start_y),
        .end_x   (end_x),
        .end_y   (end_y)
    ) u_crop (
        .clk_vp  (clk_vp),
        .rst_n_i (rst_n_i),
        .vs_i    (vi_vs_i),
        .de_i    (vi_de_i),
        .data_i  (vi_data_i),
        .we_o    (crop_we),
        .entry_o (crop_entry)
    );

    // absorbs input while line_pad is filling black
    pixel_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .clk_vp     (clk_vp),
        .rst_n_i    (rst_n_i),
        .we_i       (crop_we),
        .wdata_i    (crop_entry),
        .re_i       (scaler_re),
        .rdata_o    (fifo_rdata),
        .empty_o    (fifo_empty),
        .overflow_o (vp_overflow_o)
    );

    nn_scaler #(
        .start_x (start_x),
        .end_x   (end_x),
        .out_x   (out_x),
        .out_y   (out_y),
        .x_scale (x_scale),
        .y_scale (y_scale)
    ) u_scaler (
        .clk_vp  (clk_vp),
        .rst_n_i (rst_n_i),
        .empty_i (fifo_empty),
        .rdata_i (fifo_rdata),
        .ready_i (pad_ready),
        .re_o    (scaler_re),
        .valid_o (scl_valid),
        .pixel_o (scl_pixel),
        .sof_o   (scl_sof)
    );

    line_pad #(
        .h_disp  (h_disp),
        .out_x   (out_x)
    ) u_pad (
        .clk_vp  (clk_vp),
        .rst_n_i (rst_n_i),
        .valid_i (scl_valid),
        .pixel_i (scl_pixel),
        .sof_i   (scl_sof),
        .ready_o (pad_ready),
        .vs_o    (vp_vs_o),
        .de_o    (vp_de_o),
        .data_o  (vp_data_o)
    );

endmodule

`default_nettype wire

// File: logic/line_pad.sv
`timescale 1ns/1ps
`default_nettype none

module line_pad #(
    parameter int unsigned h_disp = 1280,
    parameter int unsigned out_x  = 320
) (
    input  wire logic            clk_vp,
    input  wire logic            rst_n_i,
    input  wire logic            valid_i,
    input  wire vp_pkg::rgb888_t pixel_i,
    input  wire logic            sof_i,
    output logic                 ready_o,
    output logic                 vs_o,
    output logic                 de_o,
    output logic [15:0]          data_o   // RGB565
);
    import vp_pkg::*;

    localparam logic [coord_w-1:0] last_col = coord_w'(out_x - 1);
    localparam logic [coord_w-1:0] pad_len  = coord_w'(h_disp - out_x);

    logic [coord_w-1:0] col;       // real pixels sent in this line
    logic [coord_w-1:0] pad_cnt;   // black pixels still owed
    rgb888_t            sk_pix [2];
    logic [1:0]         sk_sof;
    logic [1:0]         sk_cnt;    // skid fill, 0..2
    logic               padding;
    logic               use_skid;
    logic               send;      // real pixel leaves this cycle
    logic               push;
    logic               pop;
    rgb888_t            sel_pix;
    logic               sel_sof;
    logic [coord_w-1:0] col_c;

    // black fill first, then skid, then the live pixel
    assign padding  = (pad_cnt != '0);
    assign use_skid = ~padding & (sk_cnt != 2'd0);
    assign send     = ~padding & (use_skid | valid_i);
    assign pop      = use_skid;
    assign push     = valid_i & (padding | (sk_cnt != 2'd0));  // keep order behind skid
    assign sel_pix  = use_skid ? sk_pix[0] : pixel_i;
    assign sel_sof  = use_skid ? sk_sof[0] : sof_i;
    assign col_c    = sel_sof ? '0 : col;

    always_ff @(posedge clk_vp) begin
        if (!rst_n_i) begin
            col     <= '0;
            pad_cnt <= '0;
            sk_cnt  <= 2'd0;
            ready_o <= 1'b1;
            vs_o    <= 1'b0;
            de_o    <= 1'b0;
            data_o  <= '0;
        end else begin
            de_o   <= send | padding;
            vs_o   <= send & sel_sof;  // one pulse with the first pixel
            data_o <= send ? {sel_pix.r[pix_w-1 -: 5], sel_pix.g[pix_w-1 -: 6],
                              sel_pix.b[pix_w-1 -: 5]} : 16'h0000;
            if (padding) begin
                pad_cnt <= pad_cnt - 1'b1;
                if (pad_cnt == coord_w'(1)) begin
                    ready_o <= 1'b1;  // last black goes out, reopen fifo reads
                end
            end else if (send) begin
                if (col_c == last_col) begin
                    col     <= '0;
                    pad_cnt <= pad_len;
                    ready_o <= (pad_len == '0);  // two reads still in flight
                end else begin
                    col <= col_c + 1'b1;
                end
            end
            case ({push, pop})
                2'b10:   sk_cnt <= sk_cnt + 1'b1;
                2'b01:   sk_cnt <= sk_cnt - 1'b1;
                default: sk_cnt <= sk_cnt;
            endcase
        end
    end

    // skid slots, head in slot 0
    always_ff @(posedge clk_vp) begin
        if (pop) begin
            sk_pix[0] <= sk_pix[1];
            sk_sof[0] <= sk_sof[1];
        end
        if (push) begin
            if ((sk_cnt == 2'd0) || (pop && sk_cnt == 2'd1)) begin
                sk_pix[0] <= pixel_i;  // overrides the shift above
                sk_sof[0] <= sof_i;
            end else begin
                sk_pix[1] <= pixel_i;
                sk_sof[1] <= sof_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/nn_scaler.sv
`timescale 1ns/1ps
`default_nettype none

module nn_scaler #(
    parameter int unsigned start_x = 320,
    parameter int unsigned end_x   = 960,
    parameter int unsigned out_x   = 320,
    parameter int unsigned out_y   = 180,
    parameter logic [vp_pkg::scale_w-1:0] x_scale = 18'h08000,  // Q4.14, >= 1.0
    parameter logic [vp_pkg::scale_w-1:0] y_scale = 18'h08000
) (
    input  wire logic                clk_vp,
    input  wire logic                rst_n_i,
    input  wire logic                empty_i,
    input  wire vp_pkg::fifo_entry_t rdata_i,
    input  wire logic                ready_i,
    output logic                     re_o,
    output logic                     valid_o,
    output vp_pkg::rgb888_t          pixel_o,
    output logic                     sof_o
);
    import vp_pkg::*;

    // one spare integer bit so the accumulator can run past the line end
    localparam int acc_w = coord_w + scale_frac + 1;

    localparam logic [coord_w-1:0] last_ix = coord_w'(end_x - start_x - 1);
    localparam logic [coord_w-1:0] max_ox  = coord_w'(out_x);
    localparam logic [coord_w-1:0] max_oy  = coord_w'(out_y);
    localparam logic [acc_w-1:0]   step_x  = acc_w'(x_scale);
    localparam logic [acc_w-1:0]   step_y  = acc_w'(y_scale);

    logic               rd_valid;  // rdata_i holds a fresh entry
    logic [coord_w-1:0] ix;        // input column in the crop line
    logic [coord_w-1:0] iy;        // input line in the crop
    logic [coord_w-1:0] ox;        // pixels emitted in this line
    logic [coord_w-1:0] oy;        // lines emitted in this frame
    logic [acc_w-1:0]   acc_x;
    logic [acc_w-1:0]   acc_y;

    logic [coord_w-1:0] ix_c;
    logic [coord_w-1:0] iy_c;
    logic [coord_w-1:0] ox_c;
    logic [coord_w-1:0] oy_c;
    logic [acc_w-1:0]   acc_x_c;
    logic [acc_w-1:0]   acc_y_c;
    logic               line_sel;
    logic               emit;
    logic               line_end;

    assign re_o = ~empty_i & ready_i;

    // sof entry starts from a clean state
    always_comb begin
        if (rdata_i.sof) begin
            ix_c    = '0;
            iy_c    = '0;
            ox_c    = '0;
            oy_c    = '0;
            acc_x_c = '0;
            acc_y_c = '0;
        end else begin
            ix_c    = ix;
            iy_c    = iy;
            ox_c    = ox;
            oy_c    = oy;
            acc_x_c = acc_x;
            acc_y_c = acc_y;
        end
    end

    // nearest neighbour: take pixel when index hits the integer part
    assign line_sel = ({1'b0, iy_c} == acc_y_c[acc_w-1:scale_frac]) && (oy_c < max_oy);
    assign emit     = rd_valid & line_sel
                    & ({1'b0, ix_c} == acc_x_c[acc_w-1:scale_frac]) & (ox_c < max_ox);
    assign line_end = (ix_c == last_ix);

    always_ff @(posedge clk_vp) begin
        if (!rst_n_i) begin
            rd_valid <= 1'b0;
            valid_o  <= 1'b0;
            ix       <= '0;
            iy       <= '0;
            ox       <= '0;
            oy       <= '0;
            acc_x    <= '0;
            acc_y    <= '0;
        end else begin
            rd_valid <= re_o;
            valid_o  <= emit;
            if (rd_valid) begin
                if (line_end) begin
                    ix    <= '0;
                    ox    <= '0;
                    acc_x <= '0;
                    iy    <= iy_c + 1'b1;
                    acc_y <= line_sel ? acc_y_c + step_y : acc_y_c;
                    oy    <= line_sel ? oy_c + 1'b1 : oy_c;
                end else begin
                    ix    <= ix_c + 1'b1;
                    ox    <= emit ? ox_c + 1'b1 : ox_c;
                    acc_x <= emit ? acc_x_c + step_x : acc_x_c;
                    iy    <= iy_c;   // keeps a cleared frame start
                    acc_y <= acc_y_c;
                    oy    <= oy_c;
                end
            end
        end
    end

    always_ff @(posedge clk_vp) begin
        if (emit) begin
            pixel_o <= rdata_i.pix;
            sof_o   <= rdata_i.sof;
        end
    end

endmodule

`default_nettype wire

// File: logic/pixel_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo #(
    parameter int unsigned fifo_depth = 64  // power of two
) (
    input  wire logic                clk_vp,
    input  wire logic                rst_n_i,
    input  wire logic                we_i,
    input  wire vp_pkg::fifo_entry_t wdata_i,
    input  wire logic                re_i,
    output vp_pkg::fifo_entry_t      rdata_o,   // valid the cycle after re_i
    output logic                     empty_o,
    output logic                     overflow_o // sticky
);
    import vp_pkg::*;

    localparam int addr_w = $clog2(fifo_depth);

    fifo_entry_t     mem [fifo_depth];
    logic [addr_w:0] wr_ptr;  // msb is the wrap bit
    logic [addr_w:0] rd_ptr;
    logic            full;
    logic            do_wr;
    logic            do_rd;

    // same index, opposite wrap -> full
    assign empty_o = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[addr_w] != rd_ptr[addr_w])
                  && (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);
    assign do_wr   = we_i & ~full;
    assign do_rd   = re_i & ~empty_o;

    always_ff @(posedge clk_vp) begin
        if (!rst_n_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (we_i && full) begin
                overflow_o <= 1'b1;  // write lost, held until reset
            end
        end
    end

    // storage and read port
    always_ff @(posedge clk_vp) begin
        if (do_wr) begin
            mem[wr_ptr[addr_w-1:0]] <= wdata_i;
        end
        if (do_rd) begin
            rdata_o <= mem[rd_ptr[addr_w-1:0]];  // normal mode, no show-ahead
        end
    end

endmodule

`default_nettype wire

// File: logic/video_crop.sv
`timescale 1ns/1ps
`default_nettype none

module video_crop #(
    parameter int unsigned h_disp  = 1280,
    parameter int unsigned v_disp  = 720,
    parameter int unsigned start_x = 320,
    parameter int unsigned start_y = 180,
    parameter int unsigned end_x   = 960,  // exclusive
    parameter int unsigned end_y   = 540   // exclusive
) (
    input  wire logic               clk_vp,
    input  wire logic               rst_n_i,
    input  wire logic               vs_i,
    input  wire logic               de_i,
    input  wire logic [15:0]        data_i,   // RGB565
    output logic                    we_o,
    output vp_pkg::fifo_entry_t     entry_o
);
    import vp_pkg::*;

    localparam logic [coord_w-1:0] frame_w = coord_w'(h_disp);
    localparam logic [coord_w-1:0] frame_h = coord_w'(v_disp);
    localparam logic [coord_w-1:0] win_x0  = coord_w'(start_x);
    localparam logic [coord_w-1:0] win_y0  = coord_w'(start_y);
    localparam logic [coord_w-1:0] win_x1  = coord_w'(end_x);
    localparam logic [coord_w-1:0] win_y1  = coord_w'(end_y);

    logic [coord_w-1:0] x_cnt;     // column of the current beat
    logic [coord_w-1:0] y_cnt;     // line inside the frame
    logic               vs_d;
    logic               de_d;
    logic               armed;     // seen a vs edge since reset
    logic               sof_pend;  // first kept pixel still to come
    logic               vs_rise;
    logic               de_fall;
    logic               in_frame;
    logic               in_win;
    logic               keep;

    assign vs_rise  = vs_i & ~vs_d;
    assign de_fall  = de_d & ~de_i;   // end of an input line
    assign in_frame = (x_cnt < frame_w) && (y_cnt < frame_h);  // drop beats of oversize frames
    assign in_win   = (x_cnt >= win_x0) && (x_cnt < win_x1)
                   && (y_cnt >= win_y0) && (y_cnt < win_y1);
    assign keep     = de_i & ~vs_rise & armed & in_frame & in_win;

    always_ff @(posedge clk_vp) begin
        if (!rst_n_i) begin
            x_cnt    <= '0;
            y_cnt    <= '0;
            vs_d     <= 1'b0;
            de_d     <= 1'b0;
            armed    <= 1'b0;  // partial frame after reset is skipped
            sof_pend <= 1'b0;
            we_o     <= 1'b0;
        end else begin
            vs_d <= vs_i;
            de_d <= de_i;
            we_o <= keep;      // one cycle behind the beat
            if (vs_rise) begin
                x_cnt    <= '0;
                y_cnt    <= '0;
                armed    <= 1'b1;
                sof_pend <= 1'b1;
            end else if (de_i) begin
                x_cnt <= x_cnt + 1'b1;
                if (keep) begin
                    sof_pend <= 1'b0;
                end
            end else if (de_fall) begin
                x_cnt <= '0;
                y_cnt <= y_cnt + 1'b1;
            end
        end
    end

    // widen 565 to 888, low bits zero filled
    always_ff @(posedge clk_vp) begin
        if (keep) begin
            entry_o.sof   <= sof_pend;
            entry_o.pix.r <= {data_i[15:11], {(pix_w-5){1'b0}}};
            entry_o.pix.g <= {data_i[10:5], {(pix_w-6){1'b0}}};
            entry_o.pix.b <= {data_i[4:0], {(pix_w-5){1'b0}}};
        end
    end

endmodule

`default_nettype wire

// File: logic/vp_pkg.sv
`default_nettype none

// widths and pixel types shared by the crop, fifo, scaler and pad stages
package vp_pkg;

    // channel and counter widths
    parameter int pix_w      = 8;   // bits per colour channel
    parameter int coord_w    = 12;  // pixel and line counters
    parameter int scale_w    = 18;  // Q4.14 step factor
    parameter int scale_frac = 14;  // fraction bits of a step

    // one RGB888 pixel, red in the top byte
    typedef struct packed {
        logic [pix_w-1:0] r;
        logic [pix_w-1:0] g;
        logic [pix_w-1:0] b;
    } rgb888_t;

    // fifo word
    typedef struct packed {
        logic    sof;  // first kept pixel of a frame
        rgb888_t pix;
    } fifo_entry_t;

endpackage

`default_nettype wire
